//--- source/lsu_pkg.sv
/*
 * LSU shared definitions
 * Word, address and mask types, the load operation encoding
 * and the address map of the I/O region and timer window
 */

`default_nettype none

package lsu_pkg;

    // ------------------------------------------------------------
    // Basic datapath types
    // ------------------------------------------------------------

    typedef logic [31:0] data_word_t;
    typedef logic [31:0] addr_t;

    // One enable bit per byte lane, bit 0 is the lowest byte
    typedef logic [3:0] byte_mask_t;

    // ------------------------------------------------------------
    // Load operation
    // ------------------------------------------------------------

    typedef enum logic [1:0] {
        LD_BYTE = 2'b00,
        LD_HALF = 2'b01,
        LD_WORD = 2'b10
    } ld_size_t;

    // Width plus a sign extension request, 3 bits in total
    typedef struct packed {
        ld_size_t size;
        logic     is_signed;
    } ld_op_t;

    // ------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------

    // Everything below this address is I/O and is not cachable
    localparam addr_t IO_END = 32'h0000_1000;

    // The timer window holds one word inside the I/O region
    localparam addr_t TIMER_START = 32'h0000_0100;
    localparam addr_t TIMER_END   = 32'h0000_0104;

endpackage : lsu_pkg

`default_nettype wire

//--- source/store_fwd_if.sv
/*
 * Store buffer lookup channel
 * The load unit presents an address and the buffer answers
 * with a forwarding hit, its data, and a partial-word conflict
 */

`timescale 1ns/1ps
`default_nettype none

interface store_fwd_if import lsu_pkg::*; ();

    // Address of the load being checked against the buffer
    addr_t      lookup_addr;

    // Youngest matching entry covers the whole word
    logic       hit;
    data_word_t hit_data;

    // Some matching entry only covers part of the word
    logic       conflict;

    modport lookup (output lookup_addr, input hit, hit_data, conflict);

    modport buffer (input lookup_addr, output hit, hit_data, conflict);

endinterface : store_fwd_if

`default_nettype wire

//--- source/load_aligner.sv
/*
 * Load aligner
 * Picks a byte, half word or word out of a 32-bit word
 * and sign or zero extends it to the full width
 */

`timescale 1ns/1ps
`default_nettype none

module load_aligner import lsu_pkg::*; (
    input  data_word_t word_i,
    input  ld_op_t     op_i,
    input  logic [1:0] offset_i,
    output data_word_t data_o
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // Byte lane chosen by the full offset, half word by its upper bit
    assign byte_sel = word_i[8*offset_i +: 8];
    assign half_sel = word_i[16*offset_i[1] +: 16];

    always_comb begin
        case (op_i.size)
            LD_BYTE: begin
                data_o = {{24{op_i.is_signed & byte_sel[7]}}, byte_sel};
            end
            LD_HALF: begin
                data_o = {{16{op_i.is_signed & half_sel[15]}}, half_sel};
            end
            // Full word and the unused encoding pass the word through
            default: begin
                data_o = word_i;
            end
        endcase
    end

endmodule : load_aligner

`default_nettype wire

//--- source/store_buffer.sv
/*
 * Store buffer
 * Circular FIFO of masked stores, drained oldest first to the
 * memory write port, with a word search for load forwarding
 */

`timescale 1ns/1ps
`default_nettype none

module store_buffer import lsu_pkg::*; #(
    parameter int SB_DEPTH = 4
) (
    input  logic       clk_i,
    input  logic       rst_n_i,

    // Store request
    input  logic       st_valid_i,
    output logic       st_ready_o,
    input  addr_t      st_addr_i,
    input  data_word_t st_data_i,
    input  byte_mask_t st_mask_i,

    // Memory write port
    output logic       mem_wr_valid_o,
    input  logic       mem_wr_ready_i,
    output addr_t      mem_wr_addr_o,
    output data_word_t mem_wr_data_o,
    output byte_mask_t mem_wr_mask_o,

    // Lookup from the load unit
    store_fwd_if.buffer fwd
);

    localparam int PTR_W = (SB_DEPTH > 1) ? $clog2(SB_DEPTH) : 1;
    localparam int CNT_W = $clog2(SB_DEPTH + 1);

    addr_t      addr_mem [SB_DEPTH];
    data_word_t data_mem [SB_DEPTH];
    byte_mask_t mask_mem [SB_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    logic push;
    logic pop;

    // ------------------------------------------------------------
    // FIFO control
    // ------------------------------------------------------------

    assign st_ready_o     = (count_q != CNT_W'(SB_DEPTH));
    assign mem_wr_valid_o = (count_q != '0);

    assign push = st_valid_i & st_ready_o;
    assign pop  = mem_wr_valid_o & mem_wr_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(SB_DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(SB_DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
            end
            // Simultaneous push and pop leave the count unchanged
            if (push && !pop) begin
                count_q <= count_q + CNT_W'(1);
            end else if (pop && !push) begin
                count_q <= count_q - CNT_W'(1);
            end
        end
    end

    // A pushed entry becomes visible to lookups from the next cycle on
    always_ff @(posedge clk_i) begin
        if (push) begin
            addr_mem[wr_ptr_q] <= st_addr_i;
            data_mem[wr_ptr_q] <= st_data_i;
            mask_mem[wr_ptr_q] <= st_mask_i;
        end
    end

    // The oldest entry is always the one offered to memory
    assign mem_wr_addr_o = addr_mem[rd_ptr_q];
    assign mem_wr_data_o = data_mem[rd_ptr_q];
    assign mem_wr_mask_o = mask_mem[rd_ptr_q];

    // ------------------------------------------------------------
    // Forwarding search
    // ------------------------------------------------------------

    logic       youngest_full;
    logic       partial_seen;
    data_word_t match_data;

    // Walk from oldest to youngest so the last match is the youngest
    always_comb begin : search
        int idx;
        youngest_full = 1'b0;
        partial_seen  = 1'b0;
        match_data    = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            idx = int'(rd_ptr_q) + i;
            if (idx >= SB_DEPTH) begin
                idx = idx - SB_DEPTH;
            end
            if ((i < int'(count_q)) && (addr_mem[idx][31:2] == fwd.lookup_addr[31:2])) begin
                youngest_full = (mask_mem[idx] == 4'hF);
                match_data    = data_mem[idx];
                if (mask_mem[idx] != 4'hF) begin
                    partial_seen = 1'b1;
                end
            end
        end
    end : search

    assign fwd.hit      = youngest_full;
    assign fwd.hit_data = match_data;
    assign fwd.conflict = partial_seen;

endmodule : store_buffer

`default_nettype wire

//--- source/mmio_timer.sv
/*
 * Memory-mapped cycle timer
 * Free-running count of clock edges since reset was released
 */

`timescale 1ns/1ps
`default_nettype none

module mmio_timer import lsu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    output data_word_t count_o
);

    data_word_t count_q;

    // Wraps silently after 2^32 cycles
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 32'd1;
        end
    end

    assign count_o = count_q;

endmodule : mmio_timer

`default_nettype wire

//--- source/load_unit.sv
/*
 * Load unit
 * Accepts one load at a time, sources its word from the store
 * buffer, the timer or memory, and returns the aligned result
 */

`timescale 1ns/1ps
`default_nettype none

module load_unit import lsu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,

    // Load request and result
    input  logic       ld_valid_i,
    output logic       ld_ready_o,
    input  addr_t      ld_addr_i,
    input  ld_op_t     ld_op_i,
    output logic       ld_rvalid_o,
    output data_word_t ld_rdata_o,
    output logic       ld_cachable_o,

    // Timer window value
    input  data_word_t timer_value_i,

    // Memory read port
    output logic       mem_rd_req_o,
    output addr_t      mem_rd_addr_o,
    input  logic       mem_rd_valid_i,
    input  data_word_t mem_rd_data_i,

    // Aligner hookup
    output data_word_t raw_word_o,
    output ld_op_t     align_op_o,
    output logic [1:0] align_offset_o,
    input  data_word_t aligned_data_i,

    // Store buffer lookup
    store_fwd_if.lookup fwd
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        DRAIN
    } state_t;

    state_t     state_q;
    addr_t      addr_q;
    ld_op_t     op_q;
    logic       cachable_q;
    data_word_t hold_q;
    logic       use_hold_q;

    logic accept;
    logic timer_access;

    // ------------------------------------------------------------
    // Request decode
    // ------------------------------------------------------------

    assign ld_ready_o   = (state_q == IDLE);
    assign accept       = ld_valid_i & ld_ready_o;
    assign timer_access = (ld_addr_i >= TIMER_START) && (ld_addr_i < TIMER_END);

    // While idle the incoming address is searched, afterwards the held one
    assign fwd.lookup_addr = (state_q == IDLE) ? ld_addr_i : addr_q;

    // ------------------------------------------------------------
    // FSM and holding registers
    // ------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            use_hold_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        // Priority is buffer hit, then timer, then memory
                        if (fwd.hit) begin
                            state_q    <= WAIT;
                            use_hold_q <= 1'b1;
                        end else if (timer_access) begin
                            state_q    <= WAIT;
                            use_hold_q <= 1'b1;
                        end else if (fwd.conflict) begin
                            state_q    <= DRAIN;
                            use_hold_q <= 1'b0;
                        end else begin
                            state_q    <= WAIT;
                            use_hold_q <= 1'b0;
                        end
                    end
                end
                DRAIN: begin
                    // A full store that arrived meanwhile is newer than memory
                    if (!fwd.conflict) begin
                        state_q    <= WAIT;
                        use_hold_q <= fwd.hit;
                    end
                end
                WAIT: begin
                    if (ld_rvalid_o) begin
                        state_q    <= IDLE;
                        use_hold_q <= 1'b0;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Payload registers, loaded on acceptance or after the drain
    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q     <= ld_addr_i;
            op_q       <= ld_op_i;
            cachable_q <= (ld_addr_i >= IO_END);
            hold_q     <= fwd.hit ? fwd.hit_data : timer_value_i;
        end else if ((state_q == DRAIN) && !fwd.conflict) begin
            hold_q <= fwd.hit_data;
        end
    end

    // ------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------

    assign mem_rd_req_o  = (state_q == WAIT) && !use_hold_q;
    assign mem_rd_addr_o = addr_q;

    assign ld_rvalid_o = (state_q == WAIT) && (use_hold_q || mem_rd_valid_i);

    assign raw_word_o     = use_hold_q ? hold_q : mem_rd_data_i;
    assign align_op_o     = op_q;
    assign align_offset_o = addr_q[1:0];

    assign ld_rdata_o    = aligned_data_i;
    assign ld_cachable_o = cachable_q;

endmodule : load_unit

`default_nettype wire

//--- source/lsu_top.sv
/*
 * Load/store unit top level
 * Joins the load unit, store buffer, aligner and timer
 */

`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; #(
    parameter int SB_DEPTH = 4
) (
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  logic       ld_valid_i,
    output logic       ld_ready_o,
    input  addr_t      ld_addr_i,
    input  ld_op_t     ld_op_i,
    output logic       ld_rvalid_o,
    output data_word_t ld_rdata_o,
    output logic       ld_cachable_o,

    input  logic       st_valid_i,
    output logic       st_ready_o,
    input  addr_t      st_addr_i,
    input  data_word_t st_data_i,
    input  byte_mask_t st_mask_i,

    output logic       mem_rd_req_o,
    output addr_t      mem_rd_addr_o,
    input  logic       mem_rd_valid_i,
    input  data_word_t mem_rd_data_i,

    output logic       mem_wr_valid_o,
    input  logic       mem_wr_ready_i,
    output addr_t      mem_wr_addr_o,
    output data_word_t mem_wr_data_o,
    output byte_mask_t mem_wr_mask_o
);

    data_word_t timer_value;
    data_word_t raw_word;
    data_word_t aligned_data;
    ld_op_t     align_op;
    logic [1:0] align_offset;

    store_fwd_if fwd_if ();

    load_unit u_load_unit (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .ld_valid_i     (ld_valid_i),
        .ld_ready_o     (ld_ready_o),
        .ld_addr_i      (ld_addr_i),
        .ld_op_i        (ld_op_i),
        .ld_rvalid_o    (ld_rvalid_o),
        .ld_rdata_o     (ld_rdata_o),
        .ld_cachable_o  (ld_cachable_o),
        .timer_value_i  (timer_value),
        .mem_rd_req_o   (mem_rd_req_o),
        .mem_rd_addr_o  (mem_rd_addr_o),
        .mem_rd_valid_i (mem_rd_valid_i),
        .mem_rd_data_i  (mem_rd_data_i),
        .raw_word_o     (raw_word),
        .align_op_o     (align_op),
        .align_offset_o (align_offset),
        .aligned_data_i (aligned_data),
        .fwd            (fwd_if.lookup)
    );

    store_buffer #(
        .SB_DEPTH (SB_DEPTH)
    ) u_store_buffer (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .st_valid_i     (st_valid_i),
        .st_ready_o     (st_ready_o),
        .st_addr_i      (st_addr_i),
        .st_data_i      (st_data_i),
        .st_mask_i      (st_mask_i),
        .mem_wr_valid_o (mem_wr_valid_o),
        .mem_wr_ready_i (mem_wr_ready_i),
        .mem_wr_addr_o  (mem_wr_addr_o),
        .mem_wr_data_o  (mem_wr_data_o),
        .mem_wr_mask_o  (mem_wr_mask_o),
        .fwd            (fwd_if.buffer)
    );

    load_aligner u_load_aligner (
        .word_i   (raw_word),
        .op_i     (align_op),
        .offset_i (align_offset),
        .data_o   (aligned_data)
    );

    mmio_timer u_mmio_timer (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .count_o (timer_value)
    );

endmodule : lsu_top

`default_nettype wire

//--- sim/lsu_checker.sv
/*
 * LSU checker
 * Reference word model in program order, predicts load results,
 * watches latencies and buffer occupancy, and counts errors
 */

`timescale 1ns/1ps
`default_nettype none

module lsu_checker import lsu_pkg::*; #(
    parameter int SB_DEPTH = 4
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       ld_valid_i,
    input  logic       ld_ready_o,
    input  addr_t      ld_addr_i,
    input  ld_op_t     ld_op_i,
    input  logic       ld_rvalid_o,
    input  data_word_t ld_rdata_o,
    input  logic       ld_cachable_o,
    input  logic       st_valid_i,
    input  logic       st_ready_o,
    input  addr_t      st_addr_i,
    input  data_word_t st_data_i,
    input  byte_mask_t st_mask_i,
    input  logic       mem_rd_req_o,
    input  addr_t      mem_rd_addr_o,
    input  logic       mem_wr_valid_o,
    input  logic       mem_wr_ready_i,
    input  addr_t      mem_wr_addr_o,
    input  data_word_t mem_wr_data_o,
    input  byte_mask_t mem_wr_mask_o,
    input  logic       done_i,
    output int         error_count_o,
    output int         load_count_o,
    output int         store_count_o
);

    localparam int N_WORDS = 20;

    // Program-order contents and the image of what reached memory
    data_word_t model [N_WORDS];
    data_word_t image [N_WORDS];
    addr_t      pend_addr [$];
    byte_mask_t pend_mask [$];

    int         cyc;
    bit         after_reset;
    bit         busy;
    bit         fast;
    bit         final_done;
    int         acc_cyc;
    data_word_t exp_data;
    logic       exp_cach;
    addr_t      exp_addr;

    // Four I/O words at 0x200, then sixteen cachable words at IO_END
    function automatic int slot(input addr_t a);
        if (a >= IO_END) begin
            return 4 + int'((a - IO_END) >> 2);
        end
        return int'((a - 32'h200) >> 2);
    endfunction

    function automatic addr_t addr_of_slot(input int i);
        return (i < 4) ? 32'h200 + 32'(4 * i) : IO_END + 32'(4 * (i - 4));
    endfunction

    function automatic data_word_t fill(input addr_t a);
        return {a[15:0] ^ 16'hA5C3, ~(a[15:0] ^ a[31:16])};
    endfunction

    function automatic data_word_t merge(input data_word_t old, input data_word_t nw,
                                         input byte_mask_t m);
        data_word_t r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (m[b]) begin
                r[8*b +: 8] = nw[8*b +: 8];
            end
        end
        return r;
    endfunction

    // Expected register value for a load of the given word
    function automatic data_word_t predict(input data_word_t w, input ld_op_t op,
                                           input logic [1:0] off);
        data_word_t v;
        if (op.size == LD_BYTE) begin
            v = (w >> {off, 3'b000}) & 32'h0000_00FF;
            if (op.is_signed && v[7]) v = v | 32'hFFFF_FF00;
        end else if (op.size == LD_HALF) begin
            v = (w >> {off[1], 4'b0000}) & 32'h0000_FFFF;
            if (op.is_signed && v[15]) v = v | 32'hFFFF_0000;
        end else begin
            v = w;
        end
        return v;
    endfunction

    task automatic report(input string name, input data_word_t got, input data_word_t exp);
        $display("[FAIL] %s got %h expected %h", name, got, exp);
        error_count_o++;
    endtask

    always @(posedge clk_i) begin : monitor
        data_word_t word;
        bit         full_hit;
        if (!rst_n_i) begin
            for (int i = 0; i < N_WORDS; i++) begin
                model[i] = fill(addr_of_slot(i));
                image[i] = fill(addr_of_slot(i));
            end
            pend_addr.delete();
            pend_mask.delete();
            cyc         = 0;
            after_reset = 1'b1;
            busy        = 1'b0;
            final_done  = 1'b0;
        end else begin
            if (after_reset && (!ld_ready_o || ld_rvalid_o || mem_rd_req_o || mem_wr_valid_o)) begin
                $display("Outputs after reset are not in their idle state");
                error_count_o++;
            end
            after_reset = 1'b0;

            if ((pend_addr.size() < SB_DEPTH) != st_ready_o) begin
                report("st_ready_o", 32'(st_ready_o), 32'(pend_addr.size() < SB_DEPTH));
            end

            // ----------------------------------------------------------
            // Load completion, then acceptance
            // ----------------------------------------------------------
            if (busy && fast && mem_rd_req_o) begin
                $display("Memory read issued for a load served without memory");
                error_count_o++;
            end
            // The read must target the word of the accepted load
            if (busy && mem_rd_req_o && (mem_rd_addr_o[31:2] != exp_addr[31:2])) begin
                report("mem_rd_addr_o", mem_rd_addr_o, exp_addr);
            end
            if (busy && ld_rvalid_o) begin
                if (ld_rdata_o != exp_data) report("ld_rdata_o", ld_rdata_o, exp_data);
                if (ld_cachable_o != exp_cach) begin
                    report("ld_cachable_o", 32'(ld_cachable_o), 32'(exp_cach));
                end
                if (fast && (cyc != acc_cyc + 1)) begin
                    $display("Forwarded or timer load took %0d cycles", cyc - acc_cyc);
                    error_count_o++;
                end
                busy = 1'b0;
                load_count_o++;
            end
            if (ld_valid_i && ld_ready_o) begin
                full_hit = 1'b0;
                for (int i = pend_addr.size() - 1; i >= 0; i--) begin
                    if (pend_addr[i][31:2] == ld_addr_i[31:2]) begin
                        full_hit = (pend_mask[i] == 4'hF);
                        break;
                    end
                end
                if ((ld_addr_i >= TIMER_START) && (ld_addr_i < TIMER_END)) begin
                    word = 32'(cyc);
                    fast = 1'b1;
                end else begin
                    word = model[slot(ld_addr_i)];
                    fast = full_hit;
                end
                exp_data = predict(word, ld_op_i, ld_addr_i[1:0]);
                exp_cach = (ld_addr_i >= IO_END);
                exp_addr = ld_addr_i;
                acc_cyc  = cyc;
                busy     = 1'b1;
            end

            // ----------------------------------------------------------
            // Store entry and drain
            // ----------------------------------------------------------
            if (mem_wr_valid_o && mem_wr_ready_i) begin
                if (pend_addr.size() == 0) begin
                    $display("Memory write with no store pending");
                    error_count_o++;
                end else begin
                    if (mem_wr_addr_o != pend_addr[0]) begin
                        report("mem_wr_addr_o", mem_wr_addr_o, pend_addr[0]);
                    end
                    void'(pend_addr.pop_front());
                    void'(pend_mask.pop_front());
                end
                image[slot(mem_wr_addr_o)] =
                    merge(image[slot(mem_wr_addr_o)], mem_wr_data_o, mem_wr_mask_o);
            end
            if (st_valid_i && st_ready_o) begin
                model[slot(st_addr_i)] = merge(model[slot(st_addr_i)], st_data_i, st_mask_i);
                pend_addr.push_back(st_addr_i);
                pend_mask.push_back(st_mask_i);
                store_count_o++;
            end

            // Memory must end up equal to program order once drained
            if (done_i && !final_done) begin
                final_done = 1'b1;
                for (int i = 0; i < N_WORDS; i++) begin
                    if (image[i] != model[i]) report("memory word", image[i], model[i]);
                end
                if (pend_addr.size() != 0) begin
                    $display("Stores still pending at the end of the run");
                    error_count_o++;
                end
            end
            cyc++;
        end
    end : monitor

endmodule : lsu_checker

`default_nettype wire

//--- sim/lsu_tb.sv
/*
 * LSU testbench
 * Random loads and stores from an xorshift source, a memory model
 * with random read latency and write back-pressure, and a timeout
 */

`timescale 1ns/1ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

    localparam int N_TX       = 400;
    localparam int SB_DEPTH   = 4;
    localparam int MAX_CYCLES = 20 * N_TX;

    logic       clk_i;
    logic       rst_n_i;
    logic       ld_valid_i, ld_ready_o, ld_rvalid_o, ld_cachable_o;
    addr_t      ld_addr_i;
    ld_op_t     ld_op_i;
    data_word_t ld_rdata_o;
    logic       st_valid_i, st_ready_o;
    addr_t      st_addr_i;
    data_word_t st_data_i;
    byte_mask_t st_mask_i;
    logic       mem_rd_req_o, mem_rd_valid_i;
    addr_t      mem_rd_addr_o;
    data_word_t mem_rd_data_i;
    logic       mem_wr_valid_o, mem_wr_ready_i;
    addr_t      mem_wr_addr_o;
    data_word_t mem_wr_data_o;
    byte_mask_t mem_wr_mask_o;

    logic        done;
    logic        drain_all;
    int          tx_idx;
    int          rd_wait;
    int          cycles;
    int          error_count, load_count, store_count;
    logic [31:0] rng_state = 32'd46;
    data_word_t  mem [20];

    lsu_top #(.SB_DEPTH(SB_DEPTH)) dut (.*);

    lsu_checker #(.SB_DEPTH(SB_DEPTH)) chk (
        .done_i(done), .error_count_o(error_count), .load_count_o(load_count),
        .store_count_o(store_count), .*
    );

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic int mem_slot(input addr_t a);
        return (a >= IO_END) ? 4 + int'((a - IO_END) >> 2) : int'((a - 32'h200) >> 2);
    endfunction

    // Picks the timer word, one of four I/O words or one of the cachable words
    function addr_t pick_addr(input bit allow_timer);
        logic [31:0] r;
        r = next_rand();
        if (allow_timer && (r[2:0] == 3'd0)) return TIMER_START;
        if (r[2:0] < 3'd3) return 32'h200 + ((next_rand() % 4) << 2);
        return IO_END + ((next_rand() % 16) << 2);
    endfunction

    // ------------------------------------------------------------
    // Memory model
    // ------------------------------------------------------------

    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            mem_rd_valid_i = 1'b0;
            mem_wr_ready_i = 1'b0;
            rd_wait        = -1;
        end else begin
            // Early transactions see heavy write back-pressure
            if (drain_all) mem_wr_ready_i = 1'b1;
            else if (tx_idx < 120) mem_wr_ready_i = (next_rand() % 8 == 0);
            else mem_wr_ready_i = (next_rand() % 4 != 0);
            if (mem_rd_valid_i) begin
                mem_rd_valid_i = 1'b0;
                rd_wait        = -1;
            end else if (mem_rd_req_o) begin
                if (rd_wait < 0) rd_wait = int'(next_rand() % 4);
                if (rd_wait == 0) begin
                    mem_rd_valid_i = 1'b1;
                    mem_rd_data_i  = mem[mem_slot(mem_rd_addr_o)];
                end else begin
                    rd_wait--;
                end
            end
        end
    end

    always @(posedge clk_i) begin
        if (rst_n_i && mem_wr_valid_o && mem_wr_ready_i) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_wr_mask_o[b]) begin
                    mem[mem_slot(mem_wr_addr_o)][8*b +: 8] = mem_wr_data_o[8*b +: 8];
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Run exceeded %0d cycles without finishing", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------

    task automatic issue_load();
        logic [31:0] r;
        r = next_rand();
        ld_op_i = '{size: ld_size_t'(2'(r % 3)), is_signed: r[8]};
        ld_addr_i = pick_addr(1'b1);
        if (ld_op_i.size == LD_BYTE) ld_addr_i[1:0] = r[5:4];
        if (ld_op_i.size == LD_HALF) ld_addr_i[1] = r[5];
        ld_valid_i = 1'b1;
        while (!ld_ready_o) @(negedge clk_i);
        @(negedge clk_i);
        ld_valid_i = 1'b0;
        while (!ld_ready_o) @(negedge clk_i);
    endtask

    task automatic send_store();
        logic [31:0] r;
        r = next_rand();
        st_addr_i  = pick_addr(1'b0);
        st_data_i  = next_rand();
        st_mask_i  = r[0] ? 4'hF : r[7:4];
        st_valid_i = 1'b1;
        while (!st_ready_o) @(negedge clk_i);
        @(negedge clk_i);
        st_valid_i = 1'b0;
    endtask

    initial begin
        for (int i = 0; i < 20; i++) begin
            mem[i] = (i < 4) ? 32'h200 + 32'(4 * i) : IO_END + 32'(4 * (i - 4));
            mem[i] = {mem[i][15:0] ^ 16'hA5C3, ~(mem[i][15:0] ^ mem[i][31:16])};
        end
        {ld_valid_i, st_valid_i, done, drain_all} = '0;
        {mem_rd_valid_i, mem_wr_ready_i} = '0;
        ld_addr_i = '0;
        ld_op_i = '{size: LD_WORD, is_signed: 1'b0};
        {st_addr_i, st_data_i, st_mask_i, mem_rd_data_i} = '0;
        tx_idx  = 0;
        cycles  = 0;
        rst_n_i = 1'b0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);
        for (tx_idx = 0; tx_idx < N_TX; tx_idx++) begin
            if (next_rand() % 2 == 0) send_store();
            else issue_load();
        end
        drain_all = 1'b1;
        while (mem_wr_valid_o) @(negedge clk_i);
        done = 1'b1;
        repeat (2) @(negedge clk_i);
        $display("lsu_tb: %0d errors, %0d loads, %0d stores", error_count, load_count,
                 store_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : lsu_tb

`default_nettype wire

//--- build.f
source/lsu_pkg.sv
source/store_fwd_if.sv
source/load_aligner.sv
source/store_buffer.sv
source/mmio_timer.sv
source/load_unit.sv
source/lsu_top.sv
sim/lsu_checker.sv
sim/lsu_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       ?= lsu_tb
FILELIST  ?= build.f
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
